// File: build.f
accel_cfg_pkg.sv
accel_types_pkg.sv
booth_multiplier.sv
vector_bank.sv
neuron_mac.sv
wb_neuron_regs.sv
neuron_top.sv
tb_neuron.sv

// File: Bender.yml
package:
  name: neuron_accel

sources:
  - accel_cfg_pkg.sv
  - accel_types_pkg.sv
  - booth_multiplier.sv
  - vector_bank.sv
  - neuron_mac.sv
  - wb_neuron_regs.sv
  - neuron_top.sv
  - target: test
    files:
      - tb_neuron.sv

// File: tb_neuron.sv
`timescale 1ns/1ps

module tb_neuron;
    import accel_cfg_pkg::*;
    import accel_types_pkg::*;

    localparam int ACK_LIMIT  = 20;   // cycles to wait for one ack
    localparam int POLL_LIMIT = 60;   // status reads before giving up

    logic                     Clock;
    logic                     rst_n;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [WB_ADDR_WIDTH-1:0] wb_adr;
    logic [31:0]              wb_dat_w;
    logic [31:0]              wb_dat_r;
    logic                     wb_ack;

    act_t        act_m [VEC_DEPTH];  // mirror of what the banks should hold
    weight_t     wgt_m [VEC_DEPTH];
    logic [31:0] lfsr_q;
    int          check_count;
    int          error_count;
    int          timeout_count;

    neuron_top i_dut (
        .Clock    (Clock),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    task automatic finish_run();
        $display("checks: %0d  value errors: %0d  timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("timeout: no %s from the DUT", what);
        finish_run();
    endtask

    task automatic check_result(input string name, input weight_t got, input weight_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v[b]   = lfsr_q[0];
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA300_0000) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    task automatic wait_ack(input string what);
        int n;
        n = 0;
        @(negedge Clock);
        while (wb_ack !== 1'b1) begin
            if (n == ACK_LIMIT) report_timeout(what);
            n++;
            @(negedge Clock);
        end
    endtask

    // hold the request over the edge that samples ack, then release it
    task automatic end_cycle();
        @(negedge Clock);
        check_flag("wb_ack", wb_ack, 1'b0);  // one cycle ack
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [WB_ADDR_WIDTH-1:0] adr, input logic [31:0] dat);
        @(negedge Clock);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = dat;
        wait_ack("write ack");
        end_cycle();
    endtask

    task automatic wb_read(input logic [WB_ADDR_WIDTH-1:0] adr, output logic [31:0] dat);
        @(negedge Clock);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack("read ack");
        dat = wb_dat_r;  // registered with ack
        end_cycle();
    endtask

    task automatic load_pair(input int i, input act_t a, input weight_t w);
        wb_write(ADDR_ACT_BASE + WB_ADDR_WIDTH'(i), {24'd0, a});
        wb_write(ADDR_WGT_BASE + WB_ADDR_WIDTH'(i), {24'd0, w});
        act_m[i] = a;
        wgt_m[i] = w;
    endtask

    // bias plus dot product, clamped to int8
    function automatic weight_t model_result(input int len);
        int acc;
        int a;
        int w;
        acc = wgt_m[len-1];
        for (int i = 0; i < len - 1; i++) begin
            a   = act_m[i];
            w   = wgt_m[i];
            acc = acc + a * w;
        end
        if (acc > 127) acc = 127;
        if (acc < -128) acc = -128;
        return weight_t'(acc);
    endfunction

    task automatic start_neuron(input int len);
        wb_write(ADDR_CTRL, 32'h100 | 32'(len));
    endtask

    task automatic poll_done(output weight_t res);
        logic [31:0] st;
        int          n;
        n = 0;
        wb_read(ADDR_STATUS, st);
        while (st[8] !== 1'b1) begin
            if (n == POLL_LIMIT) report_timeout("done flag");
            n++;
            wb_read(ADDR_STATUS, st);
        end
        check_flag("busy at done", st[9], 1'b0);
        res = st[7:0];
    endtask

    task automatic run_neuron(input int len, input string name);
        weight_t res;
        start_neuron(len);
        poll_done(res);
        check_result(name, res, model_result(len));
    endtask

    task automatic test_reset();
        logic [31:0] st;
        wb_read(ADDR_STATUS, st);
        check_result("status result", st[7:0], '0);
        check_flag("status done", st[8], 1'b0);
        check_flag("status busy", st[9], 1'b0);
        check_flag("status upper bits", |st[31:10], 1'b0);
        wb_read(ADDR_CTRL, st);  // not readable
        check_flag("ctrl read", |st, 1'b0);
    endtask

    task automatic test_small();
        load_pair(0, 3, 4);
        load_pair(1, -2, 6);
        load_pair(2, 5, -3);
        load_pair(3, 7, 2);
        load_pair(4, 0, 10);  // bias slot
        check_result("hand model", model_result(5), 9);
        run_neuron(5, "small len 5");
        run_neuron(3, "small len 3");
    endtask

    task automatic test_saturation();
        for (int i = 0; i < VEC_DEPTH; i++) load_pair(i, 127, 127);
        run_neuron(16, "saturate high");
        for (int i = 0; i < VEC_DEPTH; i++) load_pair(i, 127, -128);
        run_neuron(16, "saturate low");
    endtask

    task automatic test_random();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] w;
        int          len;
        for (int t = 0; t < 20; t++) begin
            r   = rand_bits(4);
            len = (t == 0) ? 2 : 2 + int'(r) % 15;  // len 2 at least once
            for (int i = 0; i < len; i++) begin
                a = rand_bits(8);
                w = rand_bits(8);
                load_pair(i, a[7:0], w[7:0]);
            end
            run_neuron(len, "random run");
        end
    endtask

    task automatic test_busy();
        logic [31:0] st;
        weight_t     res;
        start_neuron(16);
        wb_write(ADDR_ACT_BASE, 32'h7f);  // dropped, model untouched
        wb_write(ADDR_WGT_BASE + 6'd15, 32'h80);
        wb_write(ADDR_CTRL, 32'h102);     // ignored start
        wb_read(ADDR_STATUS, st);
        check_flag("busy while running", st[9], 1'b1);
        poll_done(res);
        check_result("result with busy writes", res, model_result(16));
        start_neuron(16);
        wb_read(ADDR_STATUS, st);
        check_flag("done after new start", st[8], 1'b0);
        poll_done(res);
        check_result("rerun unchanged banks", res, model_result(16));
    endtask

    initial begin
        rst_n         = 1'b0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        lfsr_q        = 32'hcb7c_355d;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        for (int i = 0; i < VEC_DEPTH; i++) begin
            act_m[i] = '0;  // banks clear on reset
            wgt_m[i] = '0;
        end
        repeat (2) @(posedge Clock);
        @(negedge Clock);
        rst_n = 1'b1;

        test_reset();
        test_small();
        test_saturation();
        test_random();
        test_busy();
        finish_run();
    end

endmodule

// File: neuron_top.sv
`timescale 1ns/1ps

module neuron_top (
    input  logic                                   Clock,
    input  logic                                   rst_n,
    input  logic                                   wb_cyc,
    input  logic                                   wb_stb,
    input  logic                                   wb_we,
    input  logic [accel_cfg_pkg::WB_ADDR_WIDTH-1:0] wb_adr,
    input  logic [31:0]                            wb_dat_w,
    output logic [31:0]                            wb_dat_r,
    output logic                                   wb_ack
);
    import accel_cfg_pkg::*;
    import accel_types_pkg::*;

    logic                  act_wr_en;
    logic                  wgt_wr_en;
    logic [IDX_WIDTH-1:0]  wr_idx;
    logic [ELEM_WIDTH-1:0] wr_data;
    logic                  start;
    len_t                  len;
    logic [IDX_WIDTH-1:0]  rd_idx;
    act_t                  act;
    weight_t               wgt;
    logic                  busy;
    logic                  done;
    weight_t               result;

    wb_neuron_regs i_regs (
        .Clock     (Clock),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .busy      (busy),
        .done      (done),
        .result    (result),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .act_wr_en (act_wr_en),
        .wgt_wr_en (wgt_wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data),
        .start     (start),
        .len       (len)
    );

    vector_bank #(.elem_t(act_t)) i_act_bank (
        .Clock   (Clock),
        .rst_n   (rst_n),
        .wr_en   (act_wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .rd_idx  (rd_idx),
        .rd_data (act)
    );

    vector_bank #(.elem_t(weight_t)) i_wgt_bank (
        .Clock   (Clock),
        .rst_n   (rst_n),
        .wr_en   (wgt_wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .rd_idx  (rd_idx),  // both banks share one read index
        .rd_data (wgt)
    );

    neuron_mac i_mac (
        .Clock  (Clock),
        .rst_n  (rst_n),
        .start  (start),
        .len    (len),
        .act    (act),
        .wgt    (wgt),
        .rd_idx (rd_idx),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

endmodule

// File: wb_neuron_regs.sv
`timescale 1ns/1ps

module wb_neuron_regs (
    input  logic                                   Clock,
    input  logic                                   rst_n,
    input  logic                                   wb_cyc,
    input  logic                                   wb_stb,
    input  logic                                   wb_we,
    input  logic [accel_cfg_pkg::WB_ADDR_WIDTH-1:0] wb_adr,
    input  logic [31:0]                            wb_dat_w,
    input  logic                                   busy,
    input  logic                                   done,
    input  accel_types_pkg::weight_t               result,
    output logic [31:0]                            wb_dat_r,
    output logic                                   wb_ack,
    output logic                                   act_wr_en,
    output logic                                   wgt_wr_en,
    output logic [accel_cfg_pkg::IDX_WIDTH-1:0]    wr_idx,
    output logic [accel_cfg_pkg::ELEM_WIDTH-1:0]   wr_data,
    output logic                                   start,
    output accel_types_pkg::len_t                  len
);
    import accel_cfg_pkg::*;
    import accel_types_pkg::*;

    logic req;
    logic hit_act;
    logic hit_wgt;
    logic start_ok;
    logic done_q;

    assign req = wb_cyc && wb_stb && !wb_ack;  // one ack per request

    // upper address bits select the bank
    assign hit_act = (wb_adr[WB_ADDR_WIDTH-1:IDX_WIDTH] ==
                      ADDR_ACT_BASE[WB_ADDR_WIDTH-1:IDX_WIDTH]);
    assign hit_wgt = (wb_adr[WB_ADDR_WIDTH-1:IDX_WIDTH] ==
                      ADDR_WGT_BASE[WB_ADDR_WIDTH-1:IDX_WIDTH]);

    // start while busy gets acked but goes nowhere
    assign start_ok = req && wb_we && (wb_adr == ADDR_CTRL) && wb_dat_w[8] && !busy;

    always_ff @(posedge Clock or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack    <= 1'b0;
            wb_dat_r  <= '0;
            act_wr_en <= 1'b0;
            wgt_wr_en <= 1'b0;
            start     <= 1'b0;
            len       <= '0;
            done_q    <= 1'b0;
        end else begin
            wb_ack    <= req;
            act_wr_en <= req && wb_we && hit_act && !busy;
            wgt_wr_en <= req && wb_we && hit_wgt && !busy;
            start     <= start_ok;
            if (start_ok) len <= len_t'(wb_dat_w[IDX_WIDTH:0]);

            // sticky done, cleared by the next accepted start
            if (start_ok) begin
                done_q <= 1'b0;
            end else if (done) begin
                done_q <= 1'b1;
            end

            if (req && !wb_we && wb_adr == ADDR_STATUS) begin
                wb_dat_r <= {22'd0, busy, done_q, result};
            end else begin
                wb_dat_r <= '0;
            end
        end
    end

    // bank write payload, qualified by the enables above
    always_ff @(posedge Clock) begin
        if (req) begin
            wr_idx  <= wb_adr[IDX_WIDTH-1:0];
            wr_data <= wb_dat_w[ELEM_WIDTH-1:0];
        end
    end

    a_ack_in_cycle: assert property (@(posedge Clock) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb));

endmodule

// File: neuron_mac.sv
`timescale 1ns/1ps

module neuron_mac (
    input  logic                               Clock,
    input  logic                               rst_n,
    input  logic                               start,
    input  accel_types_pkg::len_t              len,
    input  accel_types_pkg::act_t              act,
    input  accel_types_pkg::weight_t           wgt,
    output logic [accel_cfg_pkg::IDX_WIDTH-1:0] rd_idx,
    output logic                               busy,
    output logic                               done,
    output accel_types_pkg::weight_t           result
);
    import accel_cfg_pkg::*;
    import accel_types_pkg::*;

    mac_state_t                     state_q;
    logic [IDX_WIDTH-1:0]           idx_q;
    logic [$clog2(MUL_STAGES)-1:0]  drain_q;
    acc_t                           acc_q;
    weight_t                        result_q;

    logic [IDX_WIDTH-1:0] bias_idx;
    logic [IDX_WIDTH-1:0] last_idx;
    weight_t              sat;
    logic                 mul_valid;
    product_t             mul_product;

    assign bias_idx = IDX_WIDTH'(len - len_t'(1));
    assign last_idx = IDX_WIDTH'(len - len_t'(2));  // last operand pair

    // idle points at the bias so it is ready when start arrives
    assign rd_idx = (state_q == st_idle) ? bias_idx : idx_q;

    booth_multiplier i_mul (
        .Clock        (Clock),
        .rst_n        (rst_n),
        .in_valid     (state_q == st_issue),
        .multiplicand (act),
        .multiplier   (wgt),
        .out_valid    (mul_valid),
        .product      (mul_product)
    );

    // clamp to int8
    always_comb begin
        if (acc_q > acc_t'(127)) begin
            sat = weight_t'(127);
        end else if (acc_q < acc_t'(-128)) begin
            sat = weight_t'(-128);
        end else begin
            sat = weight_t'(acc_q);
        end
    end

    always_ff @(posedge Clock or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= st_idle;
            idx_q    <= '0;
            drain_q  <= '0;
            acc_q    <= '0;
            result_q <= '0;
        end else begin
            if (state_q == st_idle && start) begin
                acc_q <= acc_t'(wgt);  // bias, sign extended
            end else if (mul_valid) begin
                acc_q <= acc_q + acc_t'(mul_product);
            end

            case (state_q)
                st_idle: begin
                    idx_q <= '0;
                    if (start) state_q <= st_issue;
                end
                st_issue: begin
                    idx_q <= idx_q + 1'b1;
                    if (idx_q == last_idx) begin
                        drain_q <= '0;
                        state_q <= st_drain;
                    end
                end
                st_drain: begin
                    drain_q <= drain_q + 1'b1;
                    if (drain_q == $bits(drain_q)'(MUL_STAGES - 1)) state_q <= st_done;
                end
                st_done: begin
                    result_q <= sat;
                    state_q  <= st_idle;
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    assign busy   = (state_q != st_idle);
    assign done   = (state_q == st_done);  // single cycle pulse
    assign result = result_q;

    // the front end must never hand over a run without a product
    a_min_len: assert property (@(posedge Clock) disable iff (!rst_n)
        (start && state_q == st_idle) |-> len >= len_t'(2));

endmodule

// File: vector_bank.sv
`timescale 1ns/1ps

module vector_bank #(
    parameter type elem_t = logic [accel_cfg_pkg::ELEM_WIDTH-1:0]
) (
    input  logic                               Clock,
    input  logic                               rst_n,
    input  logic                               wr_en,
    input  logic [accel_cfg_pkg::IDX_WIDTH-1:0] wr_idx,
    input  elem_t                              wr_data,
    input  logic [accel_cfg_pkg::IDX_WIDTH-1:0] rd_idx,
    output elem_t                              rd_data
);
    import accel_cfg_pkg::*;

    elem_t mem [VEC_DEPTH];

    // small register file, cleared so stale data never leaks into a run
    always_ff @(posedge Clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < VEC_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    assign rd_data = mem[rd_idx];  // async read

endmodule

// File: booth_multiplier.sv
`timescale 1ns/1ps

module booth_multiplier (
    input  logic                      Clock,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  accel_types_pkg::act_t     multiplicand,
    input  accel_types_pkg::weight_t  multiplier,
    output logic                      out_valid,
    output accel_types_pkg::product_t product
);
    import accel_cfg_pkg::*;
    import accel_types_pkg::*;

    // stage registers, operands only where a later stage still needs them
    product_t              part_q   [MUL_STAGES];
    act_t                  mcand_q  [MUL_STAGES-1];
    weight_t               mplier_q [MUL_STAGES-1];
    logic [MUL_STAGES-1:0] valid_q;

    // stage inputs and partial sums after this stage's steps
    product_t part_in   [MUL_STAGES];
    act_t     mcand_in  [MUL_STAGES];
    weight_t  mplier_in [MUL_STAGES];
    product_t part_nxt  [MUL_STAGES];

    // one radix-2 step, looks at bit pair (q[i], q[i-1])
    function automatic product_t booth_step(input product_t part, input act_t mcand,
                                            input weight_t mplier, input int step);
        logic [ELEM_WIDTH:0] ext;
        product_t            addend;
        ext    = {mplier, 1'b0};  // q[-1] = 0
        addend = product_t'(mcand) <<< step;
        case (ext[step +: 2])
            2'b01:   return part + addend;
            2'b10:   return part - addend;
            default: return part;
        endcase
    endfunction

    always_comb begin
        for (int s = 0; s < MUL_STAGES; s++) begin
            if (s == 0) begin
                part_in[s]   = '0;
                mcand_in[s]  = multiplicand;
                mplier_in[s] = multiplier;
            end else begin
                part_in[s]   = part_q[s-1];
                mcand_in[s]  = mcand_q[s-1];
                mplier_in[s] = mplier_q[s-1];
            end
            part_nxt[s] = part_in[s];
            for (int k = 0; k < ELEM_WIDTH / MUL_STAGES; k++) begin
                part_nxt[s] = booth_step(part_nxt[s], mcand_in[s], mplier_in[s],
                                         s * (ELEM_WIDTH / MUL_STAGES) + k);
            end
        end
    end

    always_ff @(posedge Clock) begin
        for (int s = 0; s < MUL_STAGES; s++) begin
            part_q[s] <= part_nxt[s];
        end
        for (int s = 0; s < MUL_STAGES - 1; s++) begin
            mcand_q[s]  <= mcand_in[s];  // operands travel with the partial sum
            mplier_q[s] <= mplier_in[s];
        end
    end

    always_ff @(posedge Clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[MUL_STAGES-2:0], in_valid};
        end
    end

    assign out_valid = valid_q[MUL_STAGES-1];
    assign product   = part_q[MUL_STAGES-1];

    // fixed latency and an exact product for every input pair
    a_fixed_latency: assert property (@(posedge Clock) disable iff (!rst_n)
        out_valid |-> $past(in_valid, MUL_STAGES) &&
            product == product_t'($past(multiplicand, MUL_STAGES)) *
                       product_t'($past(multiplier, MUL_STAGES)));

endmodule

// File: accel_types_pkg.sv
package accel_types_pkg;

    // operands, last used weight doubles as bias
    typedef logic signed [accel_cfg_pkg::ELEM_WIDTH-1:0] act_t;
    typedef logic signed [accel_cfg_pkg::ELEM_WIDTH-1:0] weight_t;

    // full width booth product
    typedef logic signed [2*accel_cfg_pkg::ELEM_WIDTH-1:0] product_t;

    typedef logic signed [accel_cfg_pkg::ACC_WIDTH-1:0] acc_t;

    // one bit wider than an index so 16 fits
    typedef logic [accel_cfg_pkg::IDX_WIDTH:0] len_t;

    // mac engine sequence
    typedef enum logic [1:0] {
        st_idle  = 2'b00,  // waiting for start
        st_issue = 2'b01,  // one operand pair per cycle
        st_drain = 2'b10,  // products still in flight
        st_done  = 2'b11   // saturate and flag done
    } mac_state_t;

endpackage

// File: accel_cfg_pkg.sv
package accel_cfg_pkg;

    // vector banks
    localparam int VEC_DEPTH  = 16;
    localparam int IDX_WIDTH  = 4;    // log2 of VEC_DEPTH
    localparam int ELEM_WIDTH = 8;    // int8 elements

    // multiplier pipeline, two booth steps per stage
    localparam int MUL_STAGES = 4;

    localparam int ACC_WIDTH = 32;

    // wishbone word address map
    localparam int WB_ADDR_WIDTH = 6;

    localparam logic [WB_ADDR_WIDTH-1:0] ADDR_ACT_BASE = 6'h00;  // 0x00..0x0f
    localparam logic [WB_ADDR_WIDTH-1:0] ADDR_WGT_BASE = 6'h10;  // 0x10..0x1f
    localparam logic [WB_ADDR_WIDTH-1:0] ADDR_CTRL     = 6'h20;  // start, data_len
    localparam logic [WB_ADDR_WIDTH-1:0] ADDR_STATUS   = 6'h21;  // busy, done, result

endpackage
